/* Bender.yml */
package:
  name: slurm_io

sources:
  - files:
      - source/io_bus_pkg.sv
      - source/io_regs_pkg.sv
      - source/axil_slave_port.sv
      - source/io_register_block.sv
      - source/uart_tx_serializer.sv
      - source/slurm_io_top.sv

  - target: test
    files:
      - tb/slurm_io_tb.sv

/* slurm_io.f */
source/io_bus_pkg.sv
source/io_regs_pkg.sv
source/axil_slave_port.sv
source/io_register_block.sv
source/uart_tx_serializer.sv
source/slurm_io_top.sv
tb/slurm_io_tb.sv

/* source/axil_slave_port.sv */
`timescale 1ns/1ps

module axil_slave_port
(
	input  logic                  clk,
	input  logic                  rst,
	input  io_bus_pkg::axil_req_t bus_req,
	output io_bus_pkg::axil_rsp_t bus_rsp,
	output io_bus_pkg::reg_req_t  reg_req,
	input  io_bus_pkg::reg_rsp_t  reg_rsp
);

	io_regs_pkg::port_state_e state;
	logic                     rsp_is_write; // Pending response is on the b channel
	logic [31:0]              rsp_data;
	io_bus_pkg::axil_resp_e   rsp_code;

	logic        wr_take;
	logic        rd_take;
	logic [31:0] take_addr;
	logic        addr_hit;
	logic        rsp_done;

	assign wr_take   = (state == io_regs_pkg::PORT_IDLE) && bus_req.aw_valid && bus_req.w_valid;
	assign rd_take   = (state == io_regs_pkg::PORT_IDLE) && bus_req.ar_valid && !wr_take;
	assign take_addr = wr_take ? bus_req.aw_addr : bus_req.ar_addr;
	assign addr_hit  = (take_addr[31:8] == 24'd0); // Block decodes only the low byte

	assign rsp_done = rsp_is_write ? bus_req.b_ready : bus_req.r_ready;

	always_comb
	begin
		reg_req.valid    = (wr_take || rd_take) && addr_hit;
		reg_req.write    = wr_take;
		reg_req.addr     = take_addr[7:0];
		reg_req.wdata    = bus_req.w_data;
		reg_req.lane0_en = bus_req.w_strb[0];
	end

	always_comb
	begin
		bus_rsp.aw_ready = wr_take;
		bus_rsp.w_ready  = wr_take;
		bus_rsp.ar_ready = rd_take;
		bus_rsp.b_valid  = (state == io_regs_pkg::PORT_RESP) && rsp_is_write;
		bus_rsp.b_resp   = rsp_code;
		bus_rsp.r_valid  = (state == io_regs_pkg::PORT_RESP) && !rsp_is_write;
		bus_rsp.r_data   = rsp_data;
		bus_rsp.r_resp   = rsp_code;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state        <= io_regs_pkg::PORT_IDLE;
			rsp_is_write <= 1'b0;
		end
		else
		begin
			case (state)
				io_regs_pkg::PORT_IDLE:
					if (wr_take || rd_take)
					begin
						state        <= io_regs_pkg::PORT_RESP;
						rsp_is_write <= wr_take;
					end
				io_regs_pkg::PORT_RESP:
					if (rsp_done)
						state <= io_regs_pkg::PORT_IDLE;
				default:
					state <= io_regs_pkg::PORT_IDLE;
			endcase
		end
	end

	// Response payload captured at acceptance
	always_ff @(posedge clk)
	begin
		if (wr_take || rd_take)
		begin
			rsp_data <= (rd_take && addr_hit) ? reg_rsp.rdata : 32'd0;
			rsp_code <= addr_hit ? reg_rsp.resp : io_bus_pkg::DECERR;
		end
	end

	a_one_channel: assert property (@(posedge clk) disable iff (rst)
		!(bus_rsp.b_valid && bus_rsp.r_valid));

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.b_valid && !bus_req.b_ready |=> bus_rsp.b_valid && $stable(bus_rsp.b_resp));

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		bus_rsp.r_valid && !bus_req.r_ready |=>
		bus_rsp.r_valid && $stable(bus_rsp.r_data) && $stable(bus_rsp.r_resp));

endmodule

/* source/io_bus_pkg.sv */
package io_bus_pkg;

	typedef enum logic [1:0]
	{
		OKAY   = 2'd0,
		SLVERR = 2'd2,
		DECERR = 2'd3
	} axil_resp_e;

	// Master to slave
	typedef struct packed
	{
		logic        aw_valid;
		logic [31:0] aw_addr;
		logic        w_valid;
		logic [31:0] w_data;
		logic [3:0]  w_strb;
		logic        b_ready;
		logic        ar_valid;
		logic [31:0] ar_addr;
		logic        r_ready;
	} axil_req_t;

	// Slave to master
	typedef struct packed
	{
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		axil_resp_e  b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		axil_resp_e  r_resp;
	} axil_rsp_t;

	typedef struct packed
	{
		logic        valid;
		logic        write;
		logic [7:0]  addr;     // Byte offset
		logic [31:0] wdata;
		logic        lane0_en; // Strobe bit 0
	} reg_req_t;

	typedef struct packed
	{
		logic [31:0] rdata;
		axil_resp_e  resp;
	} reg_rsp_t;

endpackage

/* source/io_register_block.sv */
`timescale 1ns/1ps

module io_register_block
(
	input  logic                             clk,
	input  logic                             rst,
	input  io_bus_pkg::reg_req_t             reg_req,
	output io_bus_pkg::reg_rsp_t             reg_rsp,
	input  logic [io_regs_pkg::BTN_W-1:0]    buttons,
	output logic [io_regs_pkg::GPIO_W-1:0]   gpio_out,
	output logic [io_regs_pkg::LED_W-1:0]    led,
	output io_regs_pkg::uart_cmd_t           uart_cmd,
	input  logic                             uart_busy
);

	logic [io_regs_pkg::GPIO_W-1:0] gpio_q;
	logic [io_regs_pkg::LED_W-1:0]  led_q;
	logic [io_regs_pkg::BTN_W-1:0]  btn_meta;
	logic [io_regs_pkg::BTN_W-1:0]  btn_sync;
	logic [io_regs_pkg::BTN_W-1:0]  btn_prev;
	logic [io_regs_pkg::BTN_W-1:0]  events_q;

	io_regs_pkg::reg_addr_e         addr;
	logic                           wr_en;
	logic                           wr_gpio;
	logic                           wr_led;
	logic [io_regs_pkg::BTN_W-1:0]  clr_mask;
	logic [io_regs_pkg::BTN_W-1:0]  btn_rise;
	logic                           uart_start;

	assign addr     = io_regs_pkg::reg_addr_e'(reg_req.addr);
	assign wr_en    = reg_req.valid && reg_req.write;
	assign btn_rise = btn_sync & ~btn_prev;

	assign gpio_out = gpio_q;
	assign led      = led_q;

	assign uart_cmd.start = uart_start;
	assign uart_cmd.data  = reg_req.wdata[7:0];

	always_comb
	begin
		reg_rsp.rdata = 32'd0;
		reg_rsp.resp  = io_bus_pkg::OKAY;
		wr_gpio       = 1'b0;
		wr_led        = 1'b0;
		clr_mask      = '0;
		uart_start    = 1'b0;
		case (addr)
			io_regs_pkg::GPIO_OUT:
			begin
				reg_rsp.rdata = {{(32 - io_regs_pkg::GPIO_W){1'b0}}, gpio_q};
				wr_gpio       = wr_en && reg_req.lane0_en;
			end
			io_regs_pkg::BUTTONS:
				reg_rsp.rdata = {{(32 - io_regs_pkg::BTN_W){1'b0}}, btn_sync};
			io_regs_pkg::BTN_EVENTS:
			begin
				reg_rsp.rdata = {{(32 - io_regs_pkg::BTN_W){1'b0}}, events_q};
				if (wr_en && reg_req.lane0_en)
					clr_mask = reg_req.wdata[io_regs_pkg::BTN_W-1:0]; // Write 1 to clear
			end
			io_regs_pkg::LED:
			begin
				reg_rsp.rdata = {{(32 - io_regs_pkg::LED_W){1'b0}}, led_q};
				wr_led        = wr_en && reg_req.lane0_en;
			end
			io_regs_pkg::UART_DATA:
				if (reg_req.write && uart_busy)
					reg_rsp.resp = io_bus_pkg::SLVERR; // Byte dropped while a frame is in progress
				else
					uart_start = wr_en && reg_req.lane0_en;
			io_regs_pkg::UART_STATUS:
				reg_rsp.rdata = {31'd0, uart_busy};
			default:
				reg_rsp.resp = io_bus_pkg::DECERR;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			gpio_q   <= '0;
			led_q    <= '0;
			btn_meta <= '0;
			btn_sync <= '0;
			btn_prev <= '0;
			events_q <= '0;
		end
		else
		begin
			btn_meta <= buttons;
			btn_sync <= btn_meta;
			btn_prev <= btn_sync;
			events_q <= (events_q & ~clr_mask) | btn_rise; // Set wins over clear
			if (wr_gpio)
				gpio_q <= reg_req.wdata[io_regs_pkg::GPIO_W-1:0];
			if (wr_led)
				led_q <= reg_req.wdata[io_regs_pkg::LED_W-1:0];
		end
	end

endmodule

/* source/io_regs_pkg.sv */
package io_regs_pkg;

	typedef enum logic [7:0]
	{
		GPIO_OUT    = 8'h00,
		BUTTONS     = 8'h04,
		BTN_EVENTS  = 8'h08,
		LED         = 8'h0C,
		UART_DATA   = 8'h10,
		UART_STATUS = 8'h14
	} reg_addr_e;

	localparam int GPIO_W = 4;
	localparam int BTN_W  = 6;
	localparam int LED_W  = 3;

	localparam int UART_CLKS_PER_BIT = 16;
	localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
	localparam logic [UART_CNT_W-1:0] UART_CNT_LAST = UART_CNT_W'(UART_CLKS_PER_BIT - 1);

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_state_e;

	typedef enum logic
	{
		PORT_IDLE,
		PORT_RESP
	} port_state_e;

	typedef struct packed
	{
		logic       start;
		logic [7:0] data;
	} uart_cmd_t;

endpackage

/* source/slurm_io_top.sv */
`timescale 1ns/1ps

module slurm_io_top
(
	input  logic                             clk,
	input  logic                             rst,
	input  io_bus_pkg::axil_req_t            bus_req,
	output io_bus_pkg::axil_rsp_t            bus_rsp,
	input  logic [io_regs_pkg::BTN_W-1:0]    buttons,
	output logic [io_regs_pkg::GPIO_W-1:0]   gpio_out,
	output logic [io_regs_pkg::LED_W-1:0]    led,
	output logic                             uart_tx
);

	io_bus_pkg::reg_req_t   reg_req;
	io_bus_pkg::reg_rsp_t   reg_rsp;
	io_regs_pkg::uart_cmd_t uart_cmd;
	logic                   uart_busy;

	axil_slave_port u_port (
		.clk     (clk),
		.rst     (rst),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.reg_req (reg_req),
		.reg_rsp (reg_rsp)
	);

	io_register_block u_regs (
		.clk       (clk),
		.rst       (rst),
		.reg_req   (reg_req),
		.reg_rsp   (reg_rsp),
		.buttons   (buttons),
		.gpio_out  (gpio_out),
		.led       (led),
		.uart_cmd  (uart_cmd),
		.uart_busy (uart_busy)
	);

	uart_tx_serializer u_uart (
		.clk       (clk),
		.rst       (rst),
		.uart_cmd  (uart_cmd),
		.uart_busy (uart_busy),
		.uart_tx   (uart_tx)
	);

endmodule

/* source/uart_tx_serializer.sv */
`timescale 1ns/1ps

module uart_tx_serializer
(
	input  logic                   clk,
	input  logic                   rst,
	input  io_regs_pkg::uart_cmd_t uart_cmd,
	output logic                   uart_busy,
	output logic                   uart_tx
);

	io_regs_pkg::uart_state_e            state;
	logic [io_regs_pkg::UART_CNT_W-1:0]  bit_cnt;  // Clocks within the current bit
	logic [2:0]                          bit_idx;
	logic [7:0]                          shreg;
	logic                                bit_end;

	assign bit_end   = (bit_cnt == io_regs_pkg::UART_CNT_LAST);
	assign uart_busy = (state != io_regs_pkg::TX_IDLE);

	always_comb
	begin
		case (state)
			io_regs_pkg::TX_START: uart_tx = 1'b0;
			io_regs_pkg::TX_DATA:  uart_tx = shreg[0]; // LSB first
			default:               uart_tx = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= io_regs_pkg::TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
		end
		else
		begin
			bit_cnt <= (state == io_regs_pkg::TX_IDLE || bit_end) ? '0 : bit_cnt + 1'b1;
			case (state)
				io_regs_pkg::TX_IDLE:
					if (uart_cmd.start)
						state <= io_regs_pkg::TX_START;
				io_regs_pkg::TX_START:
					if (bit_end)
					begin
						state   <= io_regs_pkg::TX_DATA;
						bit_idx <= '0;
					end
				io_regs_pkg::TX_DATA:
					if (bit_end)
					begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= io_regs_pkg::TX_STOP;
					end
				io_regs_pkg::TX_STOP:
					if (bit_end)
						state <= io_regs_pkg::TX_IDLE;
				default:
					state <= io_regs_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == io_regs_pkg::TX_IDLE && uart_cmd.start)
			shreg <= uart_cmd.data;
		else if (state == io_regs_pkg::TX_DATA && bit_end)
			shreg <= shreg >> 1;
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
		uart_cmd.start |-> !uart_busy);

	a_idle_line_high: assert property (@(posedge clk) disable iff (rst)
		state == io_regs_pkg::TX_IDLE |-> uart_tx);

endmodule

/* tb/slurm_io_tb.sv */
`timescale 1ns/1ps

module slurm_io_tb;

	localparam int N_REG_OPS  = 40;
	localparam int N_BTN_OPS  = 20;
	localparam int N_UART_OPS = 8;
	localparam int N_BAD_OPS  = 16;
	localparam int BIT_CLKS   = io_regs_pkg::UART_CLKS_PER_BIT;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	localparam int N_OPS      = N_REG_OPS + N_BTN_OPS + N_UART_OPS + N_BAD_OPS + 2;
	localparam longint WATCHDOG_NS = longint'(N_OPS) * (FRAME_CLKS + 64) * 100 + 10000;

	logic                  clk = 1'b0;
	logic                  rst;
	io_bus_pkg::axil_req_t bus_req;
	io_bus_pkg::axil_rsp_t bus_rsp;
	logic [5:0]            buttons;
	logic [3:0]            gpio_out;
	logic [2:0]            led;
	logic                  uart_tx;

	// Reference model state
	logic [io_regs_pkg::GPIO_W-1:0] gpio_model = '0;
	logic [io_regs_pkg::LED_W-1:0]  led_model  = '0;
	logic [io_regs_pkg::BTN_W-1:0]  btn_model  = '0;
	logic [io_regs_pkg::BTN_W-1:0]  ev_model   = '0;
	bit                             frame_started = 1'b0;
	int unsigned                    last_start;
	logic [7:0]                     exp_bytes[$];
	bit                             rx_active = 1'b0;
	int unsigned                    clk_count = 0;

	slurm_io_top DUT (
		.clk      (clk),
		.rst      (rst),
		.bus_req  (bus_req),
		.bus_rsp  (bus_rsp),
		.buttons  (buttons),
		.gpio_out (gpio_out),
		.led      (led),
		.uart_tx  (uart_tx)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		clk_count <= clk_count + 1;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic value_error(input string msg);
		fail_run($sformatf("MISMATCH at %0t: %s", $time, msg));
	endtask

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			value_error($sformatf("%s: got 0x%0h, expected 0x%0h", what, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;
	endtask

	// Busy as seen by an access accepted on clock edge accept_at
	function automatic bit uart_busy_at(input int unsigned accept_at);
		return frame_started && (accept_at - last_start <= FRAME_CLKS);
	endfunction

	function automatic bit is_mapped(input logic [31:0] addr);
		if (addr[31:8] != 24'd0)
			return 1'b0;
		case (addr[7:0])
			io_regs_pkg::GPIO_OUT, io_regs_pkg::BUTTONS, io_regs_pkg::BTN_EVENTS,
			io_regs_pkg::LED, io_regs_pkg::UART_DATA, io_regs_pkg::UART_STATUS:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output io_bus_pkg::axil_resp_e resp,
		output int unsigned accept_at);
		int unsigned stall;
		stall = $urandom_range(0, 3);
		bus_req.aw_valid = 1'b1;
		bus_req.aw_addr  = addr;
		bus_req.w_valid  = 1'b1;
		bus_req.w_data   = data;
		bus_req.w_strb   = strb;
		bus_req.b_ready  = 1'b0;
		@(negedge clk);
		while (!bus_rsp.aw_ready)
			@(negedge clk);
		expect_eq("w_ready together with aw_ready", bus_rsp.w_ready, 32'd1);
		accept_at = clk_count + 1;
		next_cycle();
		expect_eq("b_valid one cycle after acceptance", bus_rsp.b_valid, 32'd1);
		bus_req.aw_valid = 1'b0;
		bus_req.w_valid  = 1'b0;
		repeat (stall) next_cycle(); // Back-pressure on the b channel
		bus_req.b_ready = 1'b1;
		@(negedge clk);
		while (!bus_rsp.b_valid)
			@(negedge clk);
		resp = bus_rsp.b_resp;
		next_cycle();
		bus_req.b_ready = 1'b0;
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdata,
		output io_bus_pkg::axil_resp_e resp, output int unsigned accept_at);
		int unsigned stall;
		stall = $urandom_range(0, 3);
		bus_req.ar_valid = 1'b1;
		bus_req.ar_addr  = addr;
		bus_req.r_ready  = 1'b0;
		@(negedge clk);
		while (!bus_rsp.ar_ready)
			@(negedge clk);
		accept_at = clk_count + 1;
		next_cycle();
		expect_eq("r_valid one cycle after acceptance", bus_rsp.r_valid, 32'd1);
		bus_req.ar_valid = 1'b0;
		repeat (stall) next_cycle();
		bus_req.r_ready = 1'b1;
		@(negedge clk);
		while (!bus_rsp.r_valid)
			@(negedge clk);
		rdata = bus_rsp.r_data;
		resp  = bus_rsp.r_resp;
		next_cycle();
		bus_req.r_ready = 1'b0;
	endtask

	task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp, input string what);
		logic [31:0]            rdata;
		io_bus_pkg::axil_resp_e resp;
		int unsigned            acc;
		read_reg(addr, rdata, resp, acc);
		expect_eq({what, " response"}, resp, io_bus_pkg::OKAY);
		expect_eq(what, rdata, exp);
	endtask

	task automatic send_uart_byte(input logic [7:0] data);
		io_bus_pkg::axil_resp_e resp;
		int unsigned            acc;
		write_reg(io_regs_pkg::UART_DATA, {24'd0, data}, 4'hF, resp, acc);
		if (uart_busy_at(acc))
			expect_eq("UART_DATA write while busy", resp, io_bus_pkg::SLVERR);
		else
		begin
			expect_eq("UART_DATA write", resp, io_bus_pkg::OKAY);
			exp_bytes.push_back(data);
			frame_started = 1'b1;
			last_start    = acc;
		end
	endtask

	// UART monitor sampling each bit at its center
	initial
	begin
		logic [7:0] got;
		logic [7:0] exp;
		wait (rst === 1'b0);
		forever
		begin
			@(negedge uart_tx);
			rx_active = 1'b1;
			repeat (BIT_CLKS / 2) @(negedge clk);
			assert (uart_tx === 1'b0)
			else
				value_error("uart_tx start bit not low at its center");
			for (int i = 0; i < 8; i++)
			begin
				repeat (BIT_CLKS) @(negedge clk);
				got[i] = uart_tx;
			end
			assert (exp_bytes.size() > 0)
			else
				fail_run("A UART frame appeared on uart_tx with no byte expected");
			exp = exp_bytes.pop_front();
			expect_eq("UART byte", got, exp);
			repeat (BIT_CLKS) @(negedge clk);
			assert (uart_tx === 1'b1)
			else
				value_error("uart_tx stop bit not high at its center");
			rx_active = 1'b0;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		fail_run("Watchdog timeout: the test sequence hung and did not finish in time");
	end

	initial
	begin
		io_bus_pkg::axil_resp_e resp;
		logic [31:0]            data;
		logic [31:0]            addr;
		logic [3:0]             strb;
		int unsigned            acc;
		logic [5:0]             pat;

		void'($urandom(92));
		rst     = 1'b1;
		bus_req = '0;
		buttons = '0;
		repeat (8) @(posedge clk);
		#10 rst = 1'b0;
		@(negedge clk);
		expect_eq("ready/valid after reset", {bus_rsp.aw_ready, bus_rsp.w_ready,
			bus_rsp.ar_ready, bus_rsp.b_valid, bus_rsp.r_valid}, 32'd0);
		expect_eq("gpio_out after reset", gpio_out, 32'd0);
		expect_eq("led after reset", led, 32'd0);
		expect_eq("uart_tx after reset", uart_tx, 32'd1);
		next_cycle();
		read_expect(io_regs_pkg::BTN_EVENTS, 32'd0, "BTN_EVENTS after reset");
		read_expect(io_regs_pkg::UART_STATUS, 32'd0, "UART_STATUS after reset");

		for (int n = 0; n < N_REG_OPS; n++)
		begin
			addr = ($urandom_range(0, 1) == 0) ? io_regs_pkg::GPIO_OUT : io_regs_pkg::LED;
			data = $urandom;
			strb = 4'($urandom);
			write_reg(addr, data, strb, resp, acc);
			expect_eq("GPIO/LED write response", resp, io_bus_pkg::OKAY);
			if (strb[0] && addr == io_regs_pkg::GPIO_OUT)
				gpio_model = data[io_regs_pkg::GPIO_W-1:0];
			else if (strb[0])
				led_model = data[io_regs_pkg::LED_W-1:0];
			if (addr == io_regs_pkg::GPIO_OUT)
				read_expect(addr, 32'(gpio_model), "GPIO_OUT readback");
			else
				read_expect(addr, 32'(led_model), "LED readback");
			expect_eq("gpio_out pins", gpio_out, gpio_model);
			expect_eq("led pins", led, led_model);
		end

		for (int n = 0; n < N_BTN_OPS; n++)
		begin
			pat       = 6'($urandom);
			ev_model  = ev_model | (pat & ~btn_model); // Bits that rose
			btn_model = pat;
			buttons   = pat;
			repeat (4) next_cycle();
			read_expect(io_regs_pkg::BUTTONS, 32'(btn_model), "BUTTONS");
			read_expect(io_regs_pkg::BTN_EVENTS, 32'(ev_model), "BTN_EVENTS");
			data = $urandom;
			strb = 4'($urandom);
			write_reg(io_regs_pkg::BTN_EVENTS, data, strb, resp, acc);
			expect_eq("BTN_EVENTS clear response", resp, io_bus_pkg::OKAY);
			if (strb[0])
				ev_model = ev_model & ~data[io_regs_pkg::BTN_W-1:0];
			read_expect(io_regs_pkg::BTN_EVENTS, 32'(ev_model), "BTN_EVENTS after clear");
		end

		for (int n = 0; n < N_UART_OPS; n++)
		begin
			while (uart_busy_at(clk_count + 1))
				next_cycle();
			send_uart_byte(8'($urandom));
			send_uart_byte(8'($urandom)); // Lands inside the first frame
			read_reg(io_regs_pkg::UART_STATUS, data, resp, acc);
			expect_eq("UART_STATUS response", resp, io_bus_pkg::OKAY);
			expect_eq("UART_STATUS busy", data, 32'(uart_busy_at(acc)));
		end

		for (int n = 0; n < N_BAD_OPS; n++)
		begin
			addr = $urandom;
			if ($urandom_range(0, 1) == 1)
				addr[31:8] = 24'd0;
			while (is_mapped(addr))
				addr[7:0] = 8'($urandom);
			write_reg(addr, $urandom, 4'($urandom), resp, acc);
			expect_eq("unmapped write response", resp, io_bus_pkg::DECERR);
			read_reg(addr, data, resp, acc);
			expect_eq("unmapped read response", resp, io_bus_pkg::DECERR);
			expect_eq("gpio_out after unmapped access", gpio_out, gpio_model);
			expect_eq("led after unmapped access", led, led_model);
			read_expect(io_regs_pkg::BTN_EVENTS, 32'(ev_model), "BTN_EVENTS after unmapped");
		end

		while (exp_bytes.size() != 0 || rx_active)
			next_cycle();
		$display("Simulation PASSED");
		$finish;
	end

endmodule
